//--- verilog/cpu_pkg.sv
package cpu_pkg;

    localparam int INSTR_W    = 16;
    localparam int DATA_W     = 8;
    localparam int NUM_REGS   = 8;
    localparam int REG_ADDR_W = 3;

    // any opcode outside this list executes as a no-op.
    typedef enum logic [3:0] {
        HALT = 4'd0,
        LI   = 4'd1,
        ADD  = 4'd2,
        SUB  = 4'd3,
        ST   = 4'd4,
        LD   = 4'd5,
        BNZ  = 4'd6
    } opcode_t;

    // ========================================
    // debug command bytes (ASCII)
    // ========================================
    localparam logic [DATA_W-1:0] CMD_LOAD = 8'h4C;
    localparam logic [DATA_W-1:0] CMD_RUN  = 8'h52;
    localparam logic [DATA_W-1:0] CMD_STEP = 8'h53;
    localparam logic [DATA_W-1:0] CMD_MEM  = 8'h4D;

    typedef enum logic [3:0] {
        IDLE = 4'd0,
        LOAD_COUNT,
        LOAD_LO,
        LOAD_HI,
        RUN,
        STEP,
        REPORT,
        MEM_ADDR,
        MEM_SEND
    } dbg_state_t;

    // instruction field extraction.
    function automatic opcode_t instr_op(input logic [INSTR_W-1:0] instr);
        return opcode_t'(instr[15:12]);
    endfunction

    function automatic logic [REG_ADDR_W-1:0] instr_rd(input logic [INSTR_W-1:0] instr);
        return instr[11:9];
    endfunction

    function automatic logic [REG_ADDR_W-1:0] instr_rs(input logic [INSTR_W-1:0] instr);
        return instr[8:6];
    endfunction

    // imm8 overlaps rs; the opcode decides which one is meaningful.
    function automatic logic [DATA_W-1:0] instr_imm(input logic [INSTR_W-1:0] instr);
        return instr[7:0];
    endfunction

endpackage

//--- verilog/dbg_if.sv
interface dbg_if #(
    parameter int IM_ADDR_W = 6,
    parameter int DM_ADDR_W = 5
);
    import cpu_pkg::*;

    logic                  im_we;
    logic [IM_ADDR_W-1:0]  im_waddr;
    logic [INSTR_W-1:0]    im_wdata;
    logic                  exec_en;
    logic                  clear;
    logic [REG_ADDR_W-1:0] rb_addr;
    logic [DM_ADDR_W-1:0]  dm_addr;

    // readback from the datapath, all combinational.
    logic [DATA_W-1:0]     pc;
    logic                  halted;
    logic [DATA_W-1:0]     rb_data;
    logic [DATA_W-1:0]     dm_data;

    modport ctrl (
        output im_we, im_waddr, im_wdata, exec_en, clear, rb_addr, dm_addr,
        input  pc, halted, rb_data, dm_data
    );

    modport dp (
        input  im_we, im_waddr, im_wdata, exec_en, clear, rb_addr, dm_addr,
        output pc, halted, rb_data, dm_data
    );

endinterface

//--- verilog/uart_rx.sv
module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                       i_clock,
    input  logic                       i_rst,
    input  logic                       i_rx,
    output logic [cpu_pkg::DATA_W-1:0] o_data,
    output logic                       o_rx_done
);
    import cpu_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_W = $clog2(DATA_W);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state;
    logic [1:0]       rx_sync;
    logic [CNT_W-1:0] cnt;
    logic [BIT_W-1:0] bit_idx;
    logic             rx_s;

    // two flops bring the line into the clock domain. it idles high.
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
        end
    end

    assign rx_s = rx_sync[1];

    always_ff @(posedge i_clock) begin
        o_rx_done <= 1'b0;
        if (i_rst) begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (!rx_s) begin
                        state <= RX_START;
                    end
                end
                // half a bit later the start bit must still be low.
                RX_START: begin
                    if (cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        cnt   <= '0;
                        state <= rx_s ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        cnt    <= '0;
                        o_data <= {rx_s, o_data[DATA_W-1:1]};
                        if (bit_idx == BIT_W'(DATA_W - 1)) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        cnt       <= '0;
                        o_rx_done <= rx_s;
                        state     <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/uart_tx.sv
module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                       i_clock,
    input  logic                       i_rst,
    input  logic                       i_tx_start,
    input  logic [cpu_pkg::DATA_W-1:0] i_data,
    output logic                       o_tx,
    output logic                       o_tx_done
);
    import cpu_pkg::*;

    localparam int FRAME_W = DATA_W + 2;
    localparam int CNT_W   = $clog2(CLKS_PER_BIT);
    localparam int BIT_W   = $clog2(FRAME_W);

    logic               busy;
    logic [FRAME_W-1:0] frame;
    logic [CNT_W-1:0]   cnt;
    logic [BIT_W-1:0]   bit_idx;

    // frame is stop, data LSB first, start; bit 0 is on the line.
    always_ff @(posedge i_clock) begin
        o_tx_done <= 1'b0;
        if (i_rst) begin
            busy    <= 1'b0;
            o_tx    <= 1'b1;
            cnt     <= '0;
            bit_idx <= '0;
        end else if (!busy) begin
            if (i_tx_start) begin
                busy    <= 1'b1;
                frame   <= {1'b1, i_data, 1'b0};
                o_tx    <= 1'b0;
                cnt     <= '0;
                bit_idx <= '0;
            end
        end else if (cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            cnt <= '0;
            if (bit_idx == BIT_W'(FRAME_W - 1)) begin
                busy      <= 1'b0;
                o_tx      <= 1'b1;
                o_tx_done <= 1'b1;
            end else begin
                bit_idx <= bit_idx + 1'b1;
                o_tx    <= frame[1];
                frame   <= {1'b1, frame[FRAME_W-1:1]};
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- verilog/debug_unit.sv
module debug_unit #(
    parameter int IM_ADDR_W = 6,
    parameter int DM_ADDR_W = 5
) (
    input  logic                       i_clock,
    input  logic                       i_rst,
    input  logic [cpu_pkg::DATA_W-1:0] i_rx_data,
    input  logic                       i_rx_done,
    input  logic                       i_tx_done,
    output logic [cpu_pkg::DATA_W-1:0] o_tx_data,
    output logic                       o_tx_start,
    output cpu_pkg::dbg_state_t        o_state,
    dbg_if.ctrl                        o_dp
);
    import cpu_pkg::*;

    dbg_state_t           state;
    logic [DATA_W-1:0]    word_cnt;
    logic [DATA_W-1:0]    lo_byte;
    logic [IM_ADDR_W-1:0] waddr;
    logic [3:0]           rpt_idx;
    logic                 tx_wait;

    assign o_state = state;

    // report index 0 is the pc, indices 1 to 8 are r0 to r7.
    assign o_dp.rb_addr = REG_ADDR_W'(rpt_idx - 4'd1);

    always_ff @(posedge i_clock) begin
        o_tx_start  <= 1'b0;
        o_dp.im_we  <= 1'b0;
        o_dp.clear  <= 1'b0;
        if (i_rst) begin
            state        <= IDLE;
            o_dp.exec_en <= 1'b0;
            word_cnt     <= '0;
            waddr        <= '0;
            rpt_idx      <= '0;
            tx_wait      <= 1'b0;
        end else begin
            case (state)
                // ========================================
                // command decode
                // ========================================
                IDLE: begin
                    if (i_rx_done) begin
                        case (i_rx_data)
                            CMD_LOAD: begin
                                waddr <= '0;
                                state <= LOAD_COUNT;
                            end
                            CMD_RUN: begin
                                o_dp.exec_en <= 1'b1;
                                state        <= RUN;
                            end
                            CMD_STEP: begin
                                o_dp.exec_en <= 1'b1;
                                state        <= STEP;
                            end
                            CMD_MEM: state <= MEM_ADDR;
                            default: state <= IDLE;
                        endcase
                    end
                end
                LOAD_COUNT: begin
                    if (i_rx_done) begin
                        word_cnt <= i_rx_data;
                        state    <= (i_rx_data == '0) ? IDLE : LOAD_LO;
                    end
                end
                LOAD_LO: begin
                    if (i_rx_done) begin
                        lo_byte <= i_rx_data;
                        state   <= LOAD_HI;
                    end
                end
                // the high byte completes a word, which is written next cycle.
                LOAD_HI: begin
                    if (i_rx_done) begin
                        o_dp.im_we    <= 1'b1;
                        o_dp.clear    <= 1'b1;
                        o_dp.im_waddr <= waddr;
                        o_dp.im_wdata <= {i_rx_data, lo_byte};
                        waddr         <= waddr + 1'b1;
                        word_cnt      <= word_cnt - 1'b1;
                        state         <= (word_cnt == DATA_W'(1)) ? IDLE : LOAD_LO;
                    end
                end
                STEP: begin
                    o_dp.exec_en <= 1'b0;
                    rpt_idx      <= '0;
                    state        <= REPORT;
                end
                RUN: begin
                    if (o_dp.halted) begin
                        o_dp.exec_en <= 1'b0;
                        rpt_idx      <= '0;
                        state        <= REPORT;
                    end
                end
                // ========================================
                // serial replies
                // ========================================
                REPORT: begin
                    if (!tx_wait) begin
                        o_tx_data  <= (rpt_idx == '0) ? o_dp.pc : o_dp.rb_data;
                        o_tx_start <= 1'b1;
                        tx_wait    <= 1'b1;
                    end else if (i_tx_done) begin
                        tx_wait <= 1'b0;
                        if (rpt_idx == 4'(NUM_REGS)) begin
                            state <= IDLE;
                        end else begin
                            rpt_idx <= rpt_idx + 1'b1;
                        end
                    end
                end
                MEM_ADDR: begin
                    if (i_rx_done) begin
                        o_dp.dm_addr <= i_rx_data[DM_ADDR_W-1:0];
                        state        <= MEM_SEND;
                    end
                end
                MEM_SEND: begin
                    if (!tx_wait) begin
                        o_tx_data  <= o_dp.dm_data;
                        o_tx_start <= 1'b1;
                        tx_wait    <= 1'b1;
                    end else if (i_tx_done) begin
                        tx_wait <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- verilog/data_path.sv
module data_path #(
    parameter int IM_ADDR_W = 6,
    parameter int DM_ADDR_W = 5
) (
    input  logic i_clock,
    input  logic i_rst,
    dbg_if.dp    i_dbg,
    output logic o_hlt
);
    import cpu_pkg::*;

    logic [INSTR_W-1:0]    imem [2**IM_ADDR_W];
    logic [DATA_W-1:0]     regs [NUM_REGS];
    logic [DATA_W-1:0]     dmem [2**DM_ADDR_W];
    logic [IM_ADDR_W-1:0]  pc;
    logic [IM_ADDR_W-1:0]  pc_inc;
    logic                  halted;
    logic [INSTR_W-1:0]    instr;
    opcode_t               op;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs;
    logic [DATA_W-1:0]     imm;
    logic [DATA_W-1:0]     rd_val;
    logic [DATA_W-1:0]     rs_val;

    // instruction memory is only written by the debug unit.
    always_ff @(posedge i_clock) begin
        if (i_dbg.im_we) begin
            imem[i_dbg.im_waddr] <= i_dbg.im_wdata;
        end
    end

    assign instr  = imem[pc];
    assign op     = instr_op(instr);
    assign rd     = instr_rd(instr);
    assign rs     = instr_rs(instr);
    assign imm    = instr_imm(instr);
    assign rd_val = regs[rd];
    assign rs_val = regs[rs];
    assign pc_inc = pc + 1'b1;

    // ========================================
    // single-cycle execute
    // ========================================
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            pc     <= '0;
            halted <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            for (int j = 0; j < 2**DM_ADDR_W; j++) begin
                dmem[j] <= '0;
            end
        end else if (i_dbg.clear) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (i_dbg.exec_en && !halted) begin
            case (op)
                HALT: halted <= 1'b1;
                LI: begin
                    regs[rd] <= imm;
                    pc       <= pc_inc;
                end
                ADD: begin
                    regs[rd] <= rd_val + rs_val;
                    pc       <= pc_inc;
                end
                SUB: begin
                    regs[rd] <= rd_val - rs_val;
                    pc       <= pc_inc;
                end
                ST: begin
                    dmem[imm[DM_ADDR_W-1:0]] <= rd_val;
                    pc                       <= pc_inc;
                end
                LD: begin
                    regs[rd] <= dmem[imm[DM_ADDR_W-1:0]];
                    pc       <= pc_inc;
                end
                BNZ:     pc <= (rd_val != '0) ? imm[IM_ADDR_W-1:0] : pc_inc;
                default: pc <= pc_inc;
            endcase
        end
    end

    assign i_dbg.pc      = DATA_W'(pc);
    assign i_dbg.halted  = halted;
    assign i_dbg.rb_data = regs[i_dbg.rb_addr];
    assign i_dbg.dm_data = dmem[i_dbg.dm_addr];
    assign o_hlt         = halted;

endmodule

//--- verilog/top.sv
module top #(
    parameter int IM_ADDR_W    = 6,
    parameter int DM_ADDR_W    = 5,
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_uart_rx,
    output logic                o_uart_tx,
    output logic                o_hlt,
    output cpu_pkg::dbg_state_t o_state
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] rx_data;
    logic              rx_done;
    logic [DATA_W-1:0] tx_data;
    logic              tx_start;
    logic              tx_done;

    dbg_if #(.IM_ADDR_W(IM_ADDR_W), .DM_ADDR_W(DM_ADDR_W)) dbg ();

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_rx     (i_uart_rx),
        .o_data   (rx_data),
        .o_rx_done(rx_done)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
        .i_clock   (i_clock),
        .i_rst     (i_rst),
        .i_tx_start(tx_start),
        .i_data    (tx_data),
        .o_tx      (o_uart_tx),
        .o_tx_done (tx_done)
    );

    debug_unit #(.IM_ADDR_W(IM_ADDR_W), .DM_ADDR_W(DM_ADDR_W)) u_debug_unit (
        .i_clock   (i_clock),
        .i_rst     (i_rst),
        .i_rx_data (rx_data),
        .i_rx_done (rx_done),
        .i_tx_done (tx_done),
        .o_tx_data (tx_data),
        .o_tx_start(tx_start),
        .o_state   (o_state),
        .o_dp      (dbg.ctrl)
    );

    data_path #(.IM_ADDR_W(IM_ADDR_W), .DM_ADDR_W(DM_ADDR_W)) u_data_path (
        .i_clock(i_clock),
        .i_rst  (i_rst),
        .i_dbg  (dbg.dp),
        .o_hlt  (o_hlt)
    );

endmodule

//--- test/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic o_clock
);

    initial begin
        o_clock = 1'b0;
    end

    always #(PERIOD / 2) o_clock = ~o_clock;

endmodule

//--- test/tb_checker.sv
module tb_checker #(
    parameter int CLKS_PER_BIT = 16
) (
    input logic                i_clock,
    input logic                i_tx,
    input logic                i_hlt,
    input cpu_pkg::dbg_state_t i_state
);
    import cpu_pkg::*;

    logic [7:0] exp_q [$];
    string      test_name   = "none";
    logic       exp_hlt     = 1'b0;
    int         pending     = 0;
    int         test_errors = 0;
    int         test_bytes  = 0;
    int         error_count = 0;
    int         pass_count  = 0;
    int         fail_count  = 0;
    logic [7:0] rx_byte;
    logic       rx_stop;

    // ========================================
    // test bookkeeping, called from tb_top
    // ========================================
    task automatic begin_test(input string name, input logic hlt);
        test_name   = name;
        exp_hlt     = hlt;
        test_errors = 0;
        test_bytes  = 0;
    endtask

    task automatic expect_byte(input logic [7:0] value);
        exp_q.push_back(value);
        pending++;
    endtask

    task automatic end_test();
        if (i_hlt !== exp_hlt) begin
            $display("CHECK FAILED: test %s, o_hlt expected %0b, actual %0b",
                     test_name, exp_hlt, i_hlt);
            test_errors++;
            error_count++;
        end
        // every test ends with a finished command, so the debug unit is back in IDLE.
        if (i_state !== IDLE) begin
            $display("CHECK FAILED: test %s, o_state expected %0d, actual %0d",
                     test_name, IDLE, i_state);
            test_errors++;
            error_count++;
        end
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: passed, %0d reply bytes", test_name, test_bytes);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic report_counts();
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 pass_count, fail_count, error_count);
    endtask

    // ========================================
    // serial decode of the DUT reply line
    // ========================================
    // each bit is sampled near its middle on the falling clock.
    task automatic receive_byte(output logic [7:0] data, output logic stop);
        @(negedge i_tx);
        repeat (CLKS_PER_BIT / 2) @(negedge i_clock);
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge i_clock);
            data[i] = i_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge i_clock);
        stop = i_tx;
    endtask

    task automatic compare_byte(input logic [7:0] actual);
        logic [7:0] expected;
        if (exp_q.size() == 0) begin
            $display("test %s: byte 0x%02h arrived when no reply was expected",
                     test_name, actual);
            test_errors++;
            error_count++;
        end else begin
            expected = exp_q.pop_front();
            pending--;
            test_bytes++;
            if (actual !== expected) begin
                $display("CHECK FAILED: test %s, expected 0x%02h, actual 0x%02h",
                         test_name, expected, actual);
                test_errors++;
                error_count++;
            end
        end
    endtask

    always begin
        receive_byte(rx_byte, rx_stop);
        if (rx_stop !== 1'b1) begin
            $display("test %s: reply byte 0x%02h ended without a stop bit",
                     test_name, rx_byte);
            test_errors++;
            error_count++;
        end
        compare_byte(rx_byte);
    end

endmodule

//--- test/tb_top.sv
module tb_top;
    import cpu_pkg::*;

    localparam int     CLKS_PER_BIT = 16;
    localparam int     CLK_PERIOD   = 100;
    localparam longint MARGIN       = 200000;

    logic       clock;
    logic       rst;
    logic       rx_line;
    logic       tx_line;
    logic       hlt;
    dbg_state_t state;

    string      names [$];
    logic       hlt_exp [$];
    int         send_cnt [$];
    int         exp_cnt [$];
    logic [7:0] send_bytes [$];
    logic [7:0] exp_bytes [$];
    longint     limit;

    tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.o_clock(clock));

    top #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_top (
        .i_clock  (clock),
        .i_rst    (rst),
        .i_uart_rx(rx_line),
        .o_uart_tx(tx_line),
        .o_hlt    (hlt),
        .o_state  (state)
    );

    tb_checker #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_checker (
        .i_clock(clock),
        .i_tx   (tx_line),
        .i_hlt  (hlt),
        .i_state(state)
    );

    // ========================================
    // stimulus file and serial drive
    // ========================================
    task automatic read_stimulus(output int ok);
        int    fd;
        int    r;
        int    h;
        int    ns;
        int    ne;
        int    val;
        string tok;
        string rest;
        fd = $fopen("test/stimulus.txt", "r");
        ok = (fd != 0);
        if (fd != 0) begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok[0] == "#") begin
                    r = $fgets(rest, fd);
                end else begin
                    r = $fscanf(fd, "%d %d %d", h, ns, ne);
                    if (r != 3) begin
                        ok = 0;
                        h  = 0;
                        ns = 0;
                        ne = 0;
                    end
                    names.push_back(tok);
                    hlt_exp.push_back(h[0]);
                    send_cnt.push_back(ns);
                    exp_cnt.push_back(ne);
                    for (int k = 0; k < ns; k++) begin
                        r = $fscanf(fd, "%h", val);
                        if (r != 1) begin
                            ok = 0;
                        end
                        send_bytes.push_back(val[7:0]);
                    end
                    for (int k = 0; k < ne; k++) begin
                        r = $fscanf(fd, "%h", val);
                        if (r != 1) begin
                            ok = 0;
                        end
                        exp_bytes.push_back(val[7:0]);
                    end
                end
            end
            $fclose(fd);
            if (names.size() == 0) begin
                ok = 0;
            end
        end
    endtask

    // start bit, eight data bits LSB first, stop bit, then one idle bit time.
    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clock);
            #1;
            rx_line = frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clock);
        end
        @(posedge clock);
        repeat (CLKS_PER_BIT) @(posedge clock);
    endtask

    function automatic logic is_busy(input dbg_state_t s);
        return (s == RUN) || (s == STEP) || (s == REPORT) || (s == MEM_SEND);
    endfunction

    // the debug unit drops bytes while it executes or replies.
    task automatic wait_ready();
        @(negedge clock);
        while (is_busy(state)) begin
            @(negedge clock);
        end
    endtask

    task automatic run_tests();
        int sidx;
        int eidx;
        sidx = 0;
        eidx = 0;
        for (int t = 0; t < names.size(); t++) begin
            u_checker.begin_test(names[t], hlt_exp[t]);
            for (int k = 0; k < exp_cnt[t]; k++) begin
                u_checker.expect_byte(exp_bytes[eidx]);
                eidx++;
            end
            for (int k = 0; k < send_cnt[t]; k++) begin
                wait_ready();
                send_byte(send_bytes[sidx]);
                sidx++;
            end
            wait_ready();
            while (u_checker.pending != 0) begin
                @(negedge clock);
            end
            u_checker.end_test();
        end
    endtask

    initial begin
        int ok;
        rst     = 1'b1;
        rx_line = 1'b1;
        read_stimulus(ok);
        if (ok == 0) begin
            $display("could not read test/stimulus.txt");
            $display("Simulation failed");
        end else begin
            limit = longint'(send_bytes.size() + exp_bytes.size()) * 10
                    * CLKS_PER_BIT * CLK_PERIOD * 4 + MARGIN;
            fork
                begin
                    #(limit);
                    $display("timeout after %0d time units: expected replies never arrived",
                             limit);
                    $display("Simulation failed");
                    $finish;
                end
            join_none
            repeat (4) @(posedge clock);
            #1;
            rst = 1'b0;
            run_tests();
            u_checker.report_counts();
            if (u_checker.error_count == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

endmodule

//--- test/stimulus.txt
# columns: test name, expected o_hlt, bytes sent, reply bytes
# then the sent bytes and the reply bytes follow, all in hex
load_step 0 8 18
  4C 02 05 12 03 14 53 53
  01 00 05 00 00 00 00 00 00
  02 00 05 03 00 00 00 00 00
arith_wrap 1 17 9
  4C 07 03 12 05 14 80 32 C8 16 64 18 00 27 00 00 52
  06 00 FE 05 2C 64 00 00 00
run_loop 1 13 9
  4C 05 03 1A 01 1C 80 3B 02 6A 00 00 52
  04 00 FE 05 2C 64 00 01 00
reload_step 0 11 9
  4C 04 5A 1E 07 4E 07 50 00 00 53
  01 00 FE 05 2C 64 00 01 5A
store_load 0 4 19
  53 4D 07 53
  02 00 FE 05 2C 64 00 01 5A
  5A
  03 5A FE 05 2C 64 00 01 5A
unknown_cmd 1 4 10
  58 4D 07 52
  5A
  03 5A FE 05 2C 64 00 01 5A

//--- files.f
verilog/cpu_pkg.sv
verilog/dbg_if.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/debug_unit.sv
verilog/data_path.sv
verilog/top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_top.sv
